// ==== Makefile ====
# Verilator build and run for the unbalanced RAM testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_unbalanced_ram
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/dual_port_ram.sv ====
`timescale 1ns/100ps

module dual_port_ram #(
    parameter uram_pkg::ram_mode_e RAM_MODE = uram_pkg::LOW_LATENCY
) (
    input  logic                clkb,
    input  logic                rst,
    input  uram_pkg::wide_req_t a_req,
    output uram_pkg::wide_rsp_t a_rsp,
    input  uram_pkg::wide_req_t b_req,
    output uram_pkg::wide_rsp_t b_rsp
);
    import uram_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH_A;              // 128 words

    logic [DATA_WIDTH_A-1:0] mem [DEPTH];                  // storage, no reset

    wide_req_t req [2];                                    // port 0 = A, port 1 = B
    wide_rsp_t rsp [2];

    assign req[0] = a_req;
    assign req[1] = b_req;

    // both write ports share one process
    // a same-address double write is illegal, see assertion below
    always_ff @(posedge clkb) begin
        for (int p = 0; p < 2; p++) begin
            if (req[p].en && req[p].we) begin
                mem[req[p].addr] <= req[p].data;
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic                    rd_v_q;                   // first stage valid
        logic [DATA_WIDTH_A-1:0] rd_q;                     // first stage data

        always_ff @(posedge clkb) begin
            if (rst) begin
                rd_v_q <= 1'b0;
            end else begin
                rd_v_q <= req[p].en & ~req[p].we;          // read strobe
            end
        end

        // read-first, nonblocking write above lands after this sample
        always_ff @(posedge clkb) begin
            if (req[p].en && !req[p].we) begin
                rd_q <= mem[req[p].addr];
            end
        end

        if (RAM_MODE == HIGH_PERFORMANCE) begin : g_oreg
            logic                    out_v_q;              // second stage valid
            logic [DATA_WIDTH_A-1:0] out_q;                // output register

            always_ff @(posedge clkb) begin
                if (rst) begin
                    out_v_q <= 1'b0;
                end else begin
                    out_v_q <= rd_v_q;
                end
            end

            always_ff @(posedge clkb) begin
                out_q <= rd_q;                             // free-running data stage
            end

            assign rsp[p] = '{valid: out_v_q, data: out_q};
        end else begin : g_direct
            assign rsp[p] = '{valid: rd_v_q, data: rd_q};  // one cycle read
        end
    end

    assign a_rsp = rsp[0];
    assign b_rsp = rsp[1];

    // cross-port collision on one wide address is not supported
    a_no_collision : assert property (@(posedge clkb) disable iff (rst)
        (a_req.en && b_req.en && (a_req.we || b_req.we)) |-> (a_req.addr != b_req.addr))
        else $error("dual_port_ram: same-cycle cross-port access to addr %0h", a_req.addr);

endmodule

// ==== hw/subword_read_select.sv ====
`timescale 1ns/100ps

module subword_read_select #(
    parameter uram_pkg::ram_mode_e RAM_MODE    = uram_pkg::LOW_LATENCY,
    parameter int                  MUX_LATENCY = 0
) (
    input  logic                  clkb,
    input  logic                  rst,
    input  uram_pkg::narrow_req_t b_req,
    input  uram_pkg::wide_rsp_t   wb_rsp,
    output uram_pkg::narrow_rsp_t b_rsp
);
    import uram_pkg::*;

    localparam int LAT = (RAM_MODE == HIGH_PERFORMANCE) ? 2 : 1;  // ram read latency

    logic [LAT-1:0][SUB_BITS-1:0] sub_pipe_q;              // index follows its read
    logic [SUB_BITS-1:0]          sub_al;                  // index aligned to wb_rsp
    logic [DATA_WIDTH_B-1:0]      slice;                   // selected sub-word

    // index travels as far as the ram data does
    always_ff @(posedge clkb) begin
        sub_pipe_q[0] <= b_req.addr[SUB_BITS-1:0];
        for (int i = 1; i < LAT; i++) begin
            sub_pipe_q[i] <= sub_pipe_q[i-1];
        end
    end

    assign sub_al = sub_pipe_q[LAT-1];
    assign slice  = wb_rsp.data[sub_al*DATA_WIDTH_B +: DATA_WIDTH_B];

    if (MUX_LATENCY > 3) begin : g_bad_latency
        $error("subword_read_select: MUX_LATENCY %0d out of range 0..3", MUX_LATENCY);
    end

    if (MUX_LATENCY == 0) begin : g_comb
        assign b_rsp = '{valid: wb_rsp.valid, data: slice};  // no extra stage
    end else begin : g_stages
        logic [MUX_LATENCY-1:0]  v_q;                      // valid shift chain
        logic [DATA_WIDTH_B-1:0] d_q [MUX_LATENCY];        // slice shift chain

        always_ff @(posedge clkb) begin
            if (rst) begin
                v_q <= '0;
            end else begin
                v_q[0] <= wb_rsp.valid;
                for (int i = 1; i < MUX_LATENCY; i++) begin
                    v_q[i] <= v_q[i-1];
                end
            end
        end

        always_ff @(posedge clkb) begin
            d_q[0] <= slice;
            for (int i = 1; i < MUX_LATENCY; i++) begin
                d_q[i] <= d_q[i-1];
            end
        end

        assign b_rsp = '{valid: v_q[MUX_LATENCY-1], data: d_q[MUX_LATENCY-1]};

        // each narrow response has its wide response MUX_LATENCY cycles back
        a_rsp_origin : assert property (@(posedge clkb) disable iff (rst)
            b_rsp.valid |-> $past(wb_rsp.valid, MUX_LATENCY))
            else $error("subword_read_select: b_rsp.valid without wide response");
    end

endmodule

// ==== hw/subword_write_collector.sv ====
`timescale 1ns/100ps

module subword_write_collector (
    input  logic                  clkb,
    input  logic                  rst,
    input  uram_pkg::narrow_req_t b_req,
    output uram_pkg::wide_req_t   wb_req
);
    import uram_pkg::*;

    localparam int SLOTS = DEINTERLEAVE - 1;               // lower sub-words held here

    logic [SUB_BITS-1:0]                 sub;              // sub-word index of request
    logic [ADDR_WIDTH_A-1:0]             wide_addr;        // upper address bits
    logic                                top_sub;          // index 3, the commit slot
    logic                                wr;               // narrow write strobe
    logic [SLOTS-1:0][DATA_WIDTH_B-1:0]  hold_q;           // slot 2 highest

    assign sub       = b_req.addr[SUB_BITS-1:0];
    assign wide_addr = b_req.addr[ADDR_WIDTH_B-1:SUB_BITS];
    assign top_sub   = &sub;
    assign wr        = b_req.en & b_req.we;

    // holding register, filled by writes below the top sub-word
    // not cleared on commit, so old slots ride along with the next one
    always_ff @(posedge clkb) begin
        if (rst) begin
            hold_q <= '0;
        end else if (wr && !top_sub) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (sub == SUB_BITS'(i)) begin
                    hold_q[i] <= b_req.data;               // park this slice
                end
            end
        end
    end

    // wide request toward ram port B, same cycle as the narrow one
    always_comb begin
        wb_req.en   = b_req.en;                            // reads pass straight through
        wb_req.we   = wr & top_sub;                        // only the top slice commits
        wb_req.addr = wide_addr;
        wb_req.data = {b_req.data, hold_q};                // new slice over held slots
    end

    // a wide write must come from a top sub-word write
    a_commit_src : assert property (@(posedge clkb) disable iff (rst)
        wb_req.we |-> (b_req.en && b_req.we && top_sub))
        else $error("subword_write_collector: wide write without sub index 3");

endmodule

// ==== hw/unbalanced_ram.sv ====
`timescale 1ns/100ps

module unbalanced_ram #(
    parameter uram_pkg::ram_mode_e RAM_MODE    = uram_pkg::LOW_LATENCY,
    parameter int                  MUX_LATENCY = 0
) (
    input  logic                  clkb,
    input  logic                  rst,
    // wide port, full words
    input  uram_pkg::wide_req_t   a_req,
    output uram_pkg::wide_rsp_t   a_rsp,
    // narrow port, 16-bit slices
    input  uram_pkg::narrow_req_t b_req,
    output uram_pkg::narrow_rsp_t b_rsp
);
    import uram_pkg::*;

    wide_req_t wb_req;                                     // collector to ram port B
    wide_rsp_t wb_rsp;                                     // ram port B to selector

    // narrow writes gather here, top slice commits a wide write
    subword_write_collector u_collect (
        .clkb   (clkb),
        .rst    (rst),
        .b_req  (b_req),
        .wb_req (wb_req)
    );

    // shared wide storage, port A straight from outside
    dual_port_ram #(
        .RAM_MODE (RAM_MODE)
    ) u_ram (
        .clkb  (clkb),
        .rst   (rst),
        .a_req (a_req),
        .a_rsp (a_rsp),
        .b_req (wb_req),
        .b_rsp (wb_rsp)
    );

    // picks the slice out of the wide read data
    subword_read_select #(
        .RAM_MODE    (RAM_MODE),
        .MUX_LATENCY (MUX_LATENCY)
    ) u_select (
        .clkb   (clkb),
        .rst    (rst),
        .b_req  (b_req),                                   // index source
        .wb_rsp (wb_rsp),
        .b_rsp  (b_rsp)                                    // L + MUX_LATENCY after read
    );

endmodule

// ==== hw/uram_pkg.sv ====
package uram_pkg;

    // wide side, port A and the memory itself
    localparam int DATA_WIDTH_A = 64;                      // wide word
    localparam int ADDR_WIDTH_A = 7;                       // 128 wide words

    // narrow side, port B
    localparam int DEINTERLEAVE = 4;                       // sub-words per wide word
    localparam int DATA_WIDTH_B = DATA_WIDTH_A / DEINTERLEAVE;  // 16
    localparam int SUB_BITS     = $clog2(DEINTERLEAVE);    // sub-word index, 2
    localparam int ADDR_WIDTH_B = ADDR_WIDTH_A + SUB_BITS; // {wide addr, sub}

    // ram read latency choice
    typedef enum logic {
        LOW_LATENCY      = 1'b0,                           // 1 cycle read
        HIGH_PERFORMANCE = 1'b1                            // 2 cycles, registered output
    } ram_mode_e;

    // wide request, port A and the internal commit path
    typedef struct packed {
        logic                    en;                       // access strobe
        logic                    we;                       // 1 write, 0 read
        logic [ADDR_WIDTH_A-1:0] addr;
        logic [DATA_WIDTH_A-1:0] data;                     // write data
    } wide_req_t;                                          // 73 bits

    // narrow request, port B
    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [ADDR_WIDTH_B-1:0] addr;                     // low SUB_BITS pick the slice
        logic [DATA_WIDTH_B-1:0] data;
    } narrow_req_t;                                        // 27 bits

    // wide read response
    typedef struct packed {
        logic                    valid;                    // one pulse per read
        logic [DATA_WIDTH_A-1:0] data;
    } wide_rsp_t;                                          // 65 bits

    // narrow read response
    typedef struct packed {
        logic                    valid;
        logic [DATA_WIDTH_B-1:0] data;
    } narrow_rsp_t;                                        // 17 bits

endpackage

// ==== sources.f ====
hw/uram_pkg.sv
hw/dual_port_ram.sv
hw/subword_write_collector.sv
hw/subword_read_select.sv
hw/unbalanced_ram.sv
test/tb_unbalanced_ram.sv

// ==== test/tb_unbalanced_ram.sv ====
`timescale 1ns/100ps

module tb_unbalanced_ram;
    import uram_pkg::*;

    localparam ram_mode_e RAM_MODE     = HIGH_PERFORMANCE; // 2-cycle ram read
    localparam int        MUX_LATENCY  = 1;                 // one slice stage
    localparam int        CLK_PERIOD   = 10;                // ns
    localparam int        RESET_CYCLES = 8;
    localparam int        SEED         = 81;
    localparam int        DEPTH        = 2 ** ADDR_WIDTH_A;
    localparam int        RANDOM_CYCLES = 400;
    localparam int        OP_COUNT     = DEPTH + 64 + RANDOM_CYCLES;  // fill, directed, random
    localparam int        OP_BUDGET    = 4 + 2;             // cycles per op, latency and margin
    localparam int        WATCHDOG_NS  = OP_COUNT * OP_BUDGET * CLK_PERIOD
                                         + RESET_CYCLES * CLK_PERIOD;
    localparam int        DRAIN_LIMIT  = 16;                // cycles to wait for open reads

    localparam wide_req_t   WIDE_IDLE   = '0;
    localparam narrow_req_t NARROW_IDLE = '0;

    logic        clkb;
    logic        rst;
    wide_req_t   a_req;
    wide_rsp_t   a_rsp;
    narrow_req_t b_req;
    narrow_rsp_t b_rsp;

    // reference state
    logic [DATA_WIDTH_A-1:0] ref_mem  [DEPTH];              // wide words
    logic [DATA_WIDTH_B-1:0] ref_hold [DEINTERLEAVE-1];     // slots 0..2

    // expected read data, in issue order per port
    logic [DATA_WIDTH_A-1:0] exp_a_q [$];
    logic [DATA_WIDTH_B-1:0] exp_b_q [$];

    int cmp_errors;                                         // counted by the compare process
    int seq_errors;                                         // counted by the main sequence
    int wide_checks;
    int narrow_checks;

    unbalanced_ram #(
        .RAM_MODE    (RAM_MODE),
        .MUX_LATENCY (MUX_LATENCY)
    ) u_dut (
        .clkb  (clkb),
        .rst   (rst),
        .a_req (a_req),
        .a_rsp (a_rsp),
        .b_req (b_req),
        .b_rsp (b_rsp)
    );

    initial begin
        clkb = 1'b0;
        forever #(CLK_PERIOD / 2) clkb = ~clkb;
    end

    // a port A read returns the stored word
    function automatic logic [DATA_WIDTH_A-1:0] ref_wide_read(input logic [ADDR_WIDTH_A-1:0] addr);
        return ref_mem[addr];
    endfunction

    // sub 0 is bits 15:0, sub 3 is bits 63:48
    function automatic logic [DATA_WIDTH_B-1:0] ref_narrow_read(
        input logic [ADDR_WIDTH_B-1:0] addr
    );
        logic [DATA_WIDTH_A-1:0] word;
        logic [SUB_BITS-1:0]     sub;
        word = ref_mem[addr[ADDR_WIDTH_B-1:SUB_BITS]];
        sub  = addr[SUB_BITS-1:0];
        return DATA_WIDTH_B'(word >> (DATA_WIDTH_B * sub)); // wanted slice shifted to the bottom
    endfunction

    // lower slices park, top slice commits over whatever is parked
    function automatic void ref_narrow_write(input logic [ADDR_WIDTH_B-1:0] addr,
                                             input logic [DATA_WIDTH_B-1:0] data);
        logic [SUB_BITS-1:0] sub;
        sub = addr[SUB_BITS-1:0];
        if (sub == SUB_BITS'(DEINTERLEAVE - 1)) begin
            ref_mem[addr[ADDR_WIDTH_B-1:SUB_BITS]] = {data, ref_hold[2], ref_hold[1], ref_hold[0]};
        end else begin
            ref_hold[sub] = data;                           // slots survive a commit
        end
    endfunction

    // address pattern, every address bit changes the word
    function automatic logic [DATA_WIDTH_A-1:0] fill_word(input logic [ADDR_WIDTH_A-1:0] addr);
        return {8{1'b1, addr}} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic wide_req_t wide_write_req(input logic [ADDR_WIDTH_A-1:0] addr,
                                                 input logic [DATA_WIDTH_A-1:0] data);
        return '{en: 1'b1, we: 1'b1, addr: addr, data: data};
    endfunction

    function automatic wide_req_t wide_read_req(input logic [ADDR_WIDTH_A-1:0] addr);
        return '{en: 1'b1, we: 1'b0, addr: addr, data: '0};
    endfunction

    function automatic narrow_req_t narrow_write_req(input logic [ADDR_WIDTH_A-1:0] wide,
                                                     input logic [SUB_BITS-1:0]     sub,
                                                     input logic [DATA_WIDTH_B-1:0] data);
        return '{en: 1'b1, we: 1'b1, addr: {wide, sub}, data: data};
    endfunction

    function automatic narrow_req_t narrow_read_req(input logic [ADDR_WIDTH_A-1:0] wide,
                                                    input logic [SUB_BITS-1:0]     sub);
        return '{en: 1'b1, we: 1'b0, addr: {wide, sub}, data: '0};
    endfunction

    // one cycle of requests on both ports, model updated in issue order
    task automatic drive_cycle(input wide_req_t a, input narrow_req_t b);
        @(posedge clkb);
        a_req <= a;
        b_req <= b;
        if (a.en) begin
            if (a.we) begin
                ref_mem[a.addr] = a.data;
            end else begin
                exp_a_q.push_back(ref_wide_read(a.addr));
            end
        end
        if (b.en) begin
            // anything but a commit reads the wide word, parking writes too
            if (!(b.we && (&b.addr[SUB_BITS-1:0]))) begin
                exp_b_q.push_back(ref_narrow_read(b.addr));  // read-first, before the write
            end
            if (b.we) begin
                ref_narrow_write(b.addr, b.data);
            end
        end
    endtask

    // go idle and wait for every open read to come back
    task automatic wait_drained();
        int waited;
        waited = 0;
        drive_cycle(WIDE_IDLE, NARROW_IDLE);
        while ((exp_a_q.size() != 0 || exp_b_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(posedge clkb);
            waited++;
        end
        if (exp_a_q.size() != 0 || exp_b_q.size() != 0) begin
            $display("responses missing at %0t: %0d port A and %0d port B reads never answered",
                     $time, exp_a_q.size(), exp_b_q.size());
            seq_errors++;
        end
    endtask

    // both valids must be low with no read outstanding
    task automatic check_quiet();
        @(negedge clkb);
        if (a_rsp.valid !== 1'b0) begin
            $display("ERROR a_rsp.valid expected 0x0 got 0x%h at %0t", a_rsp.valid, $time);
            seq_errors++;
        end
        if (b_rsp.valid !== 1'b0) begin
            $display("ERROR b_rsp.valid expected 0x0 got 0x%h at %0t", b_rsp.valid, $time);
            seq_errors++;
        end
    endtask

    task automatic check_wide(input string name, input wide_rsp_t exp, input wide_rsp_t act);
        wide_checks++;
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h got 0x%h at %0t", name, exp.data, act.data, $time);
            cmp_errors++;
        end
    endtask

    task automatic check_narrow(input string name, input narrow_rsp_t exp, input narrow_rsp_t act);
        narrow_checks++;
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h got 0x%h at %0t", name, exp.data, act.data, $time);
            cmp_errors++;
        end
    endtask

    // scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clkb) begin : compare
        wide_rsp_t   a_exp;
        narrow_rsp_t b_exp;
        if (a_rsp.valid === 1'b1) begin
            if (exp_a_q.size() == 0) begin
                $display("port A returned a response at %0t with no read outstanding", $time);
                cmp_errors++;
            end else begin
                a_exp = '{valid: 1'b1, data: exp_a_q.pop_front()};
                check_wide("a_rsp.data", a_exp, a_rsp);
            end
        end
        if (b_rsp.valid === 1'b1) begin
            if (exp_b_q.size() == 0) begin
                $display("port B returned a response at %0t with no read outstanding", $time);
                cmp_errors++;
            end else begin
                b_exp = '{valid: 1'b1, data: exp_b_q.pop_front()};
                check_narrow("b_rsp.data", b_exp, b_rsp);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        wide_req_t               a;
        narrow_req_t             b;
        logic [ADDR_WIDTH_A-1:0] wide;
        int                      total;

        void'($urandom(SEED));
        rst   <= 1'b1;
        a_req <= WIDE_IDLE;
        b_req <= NARROW_IDLE;
        for (int i = 0; i < DEINTERLEAVE - 1; i++) begin
            ref_hold[i] = '0;                               // matches the cleared slots
        end

        // valids low all through reset, then a few quiet cycles
        repeat (RESET_CYCLES - 1) check_quiet();
        @(posedge clkb);
        rst <= 1'b0;
        repeat (4) check_quiet();

        // wide fill, then wide and narrow readback
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(wide_write_req(ADDR_WIDTH_A'(i), fill_word(ADDR_WIDTH_A'(i))), NARROW_IDLE);
        end
        for (int i = 0; i < 16; i++) begin
            drive_cycle(wide_read_req(ADDR_WIDTH_A'(i * 9 + 1)), NARROW_IDLE);  // back to back
        end
        for (int i = 0; i < 4; i++) begin
            for (int s = 0; s < DEINTERLEAVE; s++) begin
                drive_cycle(WIDE_IDLE, narrow_read_req(ADDR_WIDTH_A'(i * 31 + 5), SUB_BITS'(s)));
            end
        end
        wait_drained();

        // narrow assembly of one word, sub 3 lands on top
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd10, 2'd0, 16'h0aa0));
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd10, 2'd1, 16'h1bb1));
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd10, 2'd2, 16'h2cc2));
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd10, 2'd3, 16'h3dd3));
        drive_cycle(wide_read_req(7'd10), NARROW_IDLE);    // expects 3dd3_2cc2_1bb1_0aa0
        wait_drained();

        // parked slices stay invisible, a lone commit reuses them
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd20, 2'd0, 16'h5150));
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd20, 2'd1, 16'h5251));
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd20, 2'd2, 16'h5352));
        drive_cycle(wide_read_req(7'd20), NARROW_IDLE);    // old fill word
        drive_cycle(WIDE_IDLE, narrow_write_req(7'd30, 2'd3, 16'h6e63));
        drive_cycle(wide_read_req(7'd30), NARROW_IDLE);    // stale slots under the new top
        drive_cycle(wide_read_req(7'd20), narrow_read_req(7'd30, 2'd1));
        wait_drained();

        // random traffic on both ports, wide addresses kept apart
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            a = WIDE_IDLE;
            b = NARROW_IDLE;
            if ($urandom_range(3) != 0) begin
                a.en   = 1'b1;
                a.we   = 1'($urandom_range(1));
                a.addr = ADDR_WIDTH_A'($urandom_range(DEPTH - 1));
                a.data = {$urandom(), $urandom()};
            end
            if ($urandom_range(3) != 0) begin
                wide = ADDR_WIDTH_A'($urandom_range(DEPTH - 1));
                if (a.en && wide == a.addr) begin
                    wide = wide + 7'd1;                     // no cross-port collision
                end
                b.en   = 1'b1;
                b.we   = 1'($urandom_range(1));
                b.addr = {wide, SUB_BITS'($urandom_range(DEINTERLEAVE - 1))};
                b.data = DATA_WIDTH_B'($urandom());
            end
            drive_cycle(a, b);
        end
        wait_drained();

        if (wide_checks == 0 || narrow_checks == 0) begin
            $display("a port produced no responses to compare");
            seq_errors++;
        end

        total = cmp_errors + seq_errors;
        $display("errors: %0d (%0d compare, %0d sequence), %0d wide and %0d narrow responses checked",
                 total, cmp_errors, seq_errors, wide_checks, narrow_checks);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
